// ==== rtl/isaPkg.sv ====
package isaPkg;

	// ==========================================================
	// Opcodes in bits 15:11
	// ==========================================================
	localparam logic [4:0] OpHalt = 5'b00000;
	localparam logic [4:0] OpNop  = 5'b00001;
	localparam logic [4:0] OpAddi = 5'b01000;
	localparam logic [4:0] OpXori = 5'b01010;
	localparam logic [4:0] OpLbi  = 5'b11000;
	// ALU group decodes on bits 15:12 only, so bit 11 is free for the function
	localparam logic [4:0] OpAlu  = 5'b11010;

	// ALU layout is op | rs | rt | rd | fn, the I layout is op | rd | rs | imm
	localparam int OpMsb   = 15;
	localparam int OpLsb   = 11;
	localparam int RsMsb   = 10;
	localparam int RsLsb   = 8;
	localparam int RtMsb   = 7;
	localparam int RtLsb   = 5;
	localparam int RdMsb   = 4;
	localparam int RdLsb   = 2;
	localparam int FnHiPos = 11;
	localparam int FnMsb   = 1;
	localparam int FnLsb   = 0;
	localparam int IRdMsb  = 10;
	localparam int IRdLsb  = 8;
	localparam int IRsMsb  = 7;
	localparam int IRsLsb  = 5;
	localparam int Imm5Msb = 4;
	localparam int Imm8Msb = 7;

	typedef enum logic [3:0] {
		AluAdd   = 4'd0,
		AluSub   = 4'd1,
		AluXor   = 4'd2,
		AluAndn  = 4'd3,
		AluRol   = 4'd4,
		AluSll   = 4'd5,
		AluSrl   = 4'd6,
		AluPassB = 4'd7
	} aluOp_e;

	// Function codes, built as {instr[FnHiPos], instr[FnMsb:FnLsb]}
	localparam logic [2:0] FnAdd  = 3'd0;
	localparam logic [2:0] FnSub  = 3'd1;
	localparam logic [2:0] FnXor  = 3'd2;
	localparam logic [2:0] FnAndn = 3'd3;
	localparam logic [2:0] FnRol  = 3'd4;
	localparam logic [2:0] FnSll  = 3'd5;
	localparam logic [2:0] FnSrl  = 3'd6;

	function automatic logic isAluOpcode(input logic [4:0] op);
		return op[4:1] == OpAlu[4:1];
	endfunction

	function automatic logic funcLegal(input logic [2:0] fn);
		return fn != 3'd7;
	endfunction

	function automatic aluOp_e funcToAluOp(input logic [2:0] fn);
		case (fn)
			FnAdd:   return AluAdd;
			FnSub:   return AluSub;
			FnXor:   return AluXor;
			FnAndn:  return AluAndn;
			FnRol:   return AluRol;
			FnSll:   return AluSll;
			FnSrl:   return AluSrl;
			default: return AluAdd;
		endcase
	endfunction

endpackage

// ==== rtl/corePkg.sv ====
package corePkg;

	localparam int WordWidth = 16;
	localparam int NumRegs   = 8;

	// Data and instruction words share one width
	typedef logic [WordWidth-1:0] word_t;
	typedef logic [2:0]           regSel_t;

	// Immediate after sign or zero extension
	typedef word_t imm_t;

	// ==========================================================
	// Control word carried from decode into execute
	// ==========================================================
	// Bit 15 selects the immediate, 14:11 hold an aluOp_e value,
	// 1 is halt and 0 is the register write enable
	typedef struct packed {
		logic       aluSrc2;
		logic [3:0] aluCtrl;
		logic [8:0] reserved;
		logic       halt;
		logic       regWrite;
	} ctrl_t;

endpackage

// ==== rtl/instrDecode.sv ====
module instrDecode (
	input  corePkg::word_t   instr,
	input  logic             instrValid,
	input  corePkg::word_t   rdData1,
	input  corePkg::word_t   rdData2,
	input  logic             fwdEn,
	input  corePkg::regSel_t fwdReg,
	input  corePkg::word_t   fwdData,
	output corePkg::regSel_t rdSel1,
	output corePkg::regSel_t rdSel2,
	output corePkg::ctrl_t   ctrl,
	output corePkg::regSel_t destReg,
	output corePkg::word_t   opA,
	output corePkg::word_t   opB,
	output corePkg::imm_t    imm,
	output logic             illegal
);

	logic [4:0]       opcode;
	logic [2:0]       func;
	corePkg::ctrl_t   ctrlRaw;
	corePkg::regSel_t src1;
	corePkg::regSel_t dest;
	corePkg::imm_t    immExt;
	logic             bad;

	assign opcode = instr[isaPkg::OpMsb:isaPkg::OpLsb];
	assign func   = {instr[isaPkg::FnHiPos], instr[isaPkg::FnMsb:isaPkg::FnLsb]};

	always_comb begin
		ctrlRaw = '0;
		immExt  = '0;
		bad     = 1'b0;
		src1    = instr[isaPkg::IRsMsb:isaPkg::IRsLsb];
		dest    = instr[isaPkg::IRdMsb:isaPkg::IRdLsb];
		if (isaPkg::isAluOpcode(opcode)) begin
			src1 = instr[isaPkg::RsMsb:isaPkg::RsLsb];
			dest = instr[isaPkg::RdMsb:isaPkg::RdLsb];
			if (isaPkg::funcLegal(func)) begin
				ctrlRaw.aluCtrl  = isaPkg::funcToAluOp(func);
				ctrlRaw.regWrite = 1'b1;
			end else begin
				bad = 1'b1;
			end
		end else begin
			case (opcode)
				isaPkg::OpHalt: ctrlRaw.halt = 1'b1;
				isaPkg::OpNop: ;
				isaPkg::OpAddi: begin
					ctrlRaw.aluSrc2  = 1'b1;
					ctrlRaw.aluCtrl  = isaPkg::AluAdd;
					ctrlRaw.regWrite = 1'b1;
					immExt = {{(15 - isaPkg::Imm5Msb){instr[isaPkg::Imm5Msb]}},
						instr[isaPkg::Imm5Msb:0]};
				end
				isaPkg::OpXori: begin
					ctrlRaw.aluSrc2  = 1'b1;
					ctrlRaw.aluCtrl  = isaPkg::AluXor;
					ctrlRaw.regWrite = 1'b1;
					// Logical immediates are zero extended
					immExt = {{(15 - isaPkg::Imm5Msb){1'b0}}, instr[isaPkg::Imm5Msb:0]};
				end
				isaPkg::OpLbi: begin
					ctrlRaw.aluSrc2  = 1'b1;
					ctrlRaw.aluCtrl  = isaPkg::AluPassB;
					ctrlRaw.regWrite = 1'b1;
					immExt = {{(15 - isaPkg::Imm8Msb){instr[isaPkg::Imm8Msb]}},
						instr[isaPkg::Imm8Msb:0]};
				end
				default: bad = 1'b1;
			endcase
		end
	end

	// Nothing writes or halts unless the slot carries an instruction
	always_comb begin
		ctrl          = ctrlRaw;
		ctrl.regWrite = ctrlRaw.regWrite & instrValid;
		ctrl.halt     = ctrlRaw.halt & instrValid;
	end

	assign illegal = bad & instrValid;
	assign destReg = dest;
	assign imm     = immExt;
	assign rdSel1  = src1;
	assign rdSel2  = instr[isaPkg::RtMsb:isaPkg::RtLsb];

	// The instruction ahead has not written back yet, so take its result
	assign opA = (fwdEn && fwdReg == src1) ? fwdData : rdData1;
	assign opB = (fwdEn && fwdReg == rdSel2) ? fwdData : rdData2;

endmodule

// ==== rtl/regFile.sv ====
module regFile (
	input  logic             clk,
	input  logic             rstN,
	input  corePkg::regSel_t rdSel1,
	input  corePkg::regSel_t rdSel2,
	input  logic             wrEn,
	input  corePkg::regSel_t wrSel,
	input  corePkg::word_t   wrData,
	output corePkg::word_t   rdData1,
	output corePkg::word_t   rdData2
);

	corePkg::word_t regs [corePkg::NumRegs];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < corePkg::NumRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn) begin
			regs[wrSel] <= wrData;
		end
	end

	// Register 0 is an ordinary register here
	assign rdData1 = regs[rdSel1];
	assign rdData2 = regs[rdSel2];

endmodule

// ==== rtl/idExReg.sv ====
module idExReg (
	input  logic             clk,
	input  logic             rstN,
	input  corePkg::ctrl_t   ctrlIn,
	input  corePkg::word_t   opAIn,
	input  corePkg::word_t   opBIn,
	input  corePkg::imm_t    immIn,
	input  corePkg::regSel_t destIn,
	input  logic             validIn,
	input  logic             illegalIn,
	output corePkg::ctrl_t   ctrlOut,
	output corePkg::word_t   opAOut,
	output corePkg::word_t   opBOut,
	output corePkg::imm_t    immOut,
	output corePkg::regSel_t destOut,
	output logic             validOut,
	output logic             errOut
);

	corePkg::ctrl_t ctrlQ;
	logic           validQ;
	logic           illegalQ;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			validQ <= 1'b0;
		end else begin
			validQ <= validIn;
		end
	end

	// Payload loads every cycle and only means something while validQ is set
	always_ff @(posedge clk) begin
		ctrlQ    <= ctrlIn;
		opAOut   <= opAIn;
		opBOut   <= opBIn;
		immOut   <= immIn;
		destOut  <= destIn;
		illegalQ <= illegalIn;
	end

	always_comb begin
		ctrlOut          = ctrlQ;
		ctrlOut.regWrite = ctrlQ.regWrite & validQ;
		ctrlOut.halt     = ctrlQ.halt & validQ;
	end

	assign validOut = validQ;
	assign errOut   = illegalQ & validQ;

endmodule

// ==== rtl/aluExec.sv ====
module aluExec (
	input  logic             clk,
	input  logic             rstN,
	input  corePkg::ctrl_t   ctrl,
	input  corePkg::word_t   opA,
	input  corePkg::word_t   opB,
	input  corePkg::imm_t    imm,
	input  corePkg::regSel_t dest,
	input  logic             valid,
	input  logic             errIn,
	output corePkg::word_t   aluResult,
	output logic             wbValid,
	output corePkg::regSel_t wbReg,
	output corePkg::word_t   wbData,
	output logic             err,
	output logic             haltSeen
);

	corePkg::word_t srcB;
	logic [3:0]     amt;
	logic [31:0]    rotWide;

	assign srcB    = ctrl.aluSrc2 ? imm : opB;
	assign amt     = srcB[3:0];
	assign rotWide = {opA, opA} << amt;

	always_comb begin
		case (isaPkg::aluOp_e'(ctrl.aluCtrl))
			isaPkg::AluAdd:   aluResult = opA + srcB;
			isaPkg::AluSub:   aluResult = opA - srcB;
			isaPkg::AluXor:   aluResult = opA ^ srcB;
			isaPkg::AluAndn:  aluResult = opA & ~srcB;
			isaPkg::AluRol:   aluResult = rotWide[31:16];
			isaPkg::AluSll:   aluResult = opA << amt;
			isaPkg::AluSrl:   aluResult = opA >> amt;
			isaPkg::AluPassB: aluResult = srcB;
			default:          aluResult = '0;
		endcase
	end

	// ==========================================================
	// Execute/writeback register
	// ==========================================================
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			wbValid  <= 1'b0;
			err      <= 1'b0;
			haltSeen <= 1'b0;
		end else begin
			wbValid  <= valid & ctrl.regWrite;
			err      <= errIn;
			haltSeen <= valid & ctrl.halt;
		end
	end

	always_ff @(posedge clk) begin
		wbReg  <= dest;
		wbData <= aluResult;
	end

endmodule

// ==== rtl/decodeExecCore.sv ====
module decodeExecCore (
	input  logic             clk,
	input  logic             rstN,
	input  corePkg::word_t   instr,
	input  logic             instrValid,
	output logic             wbValid,
	output corePkg::regSel_t wbReg,
	output corePkg::word_t   wbData,
	output logic             err,
	output logic             halted
);

	corePkg::regSel_t rdSel1;
	corePkg::regSel_t rdSel2;
	corePkg::word_t   rdData1;
	corePkg::word_t   rdData2;
	corePkg::ctrl_t   decCtrl;
	corePkg::regSel_t decDest;
	corePkg::word_t   decOpA;
	corePkg::word_t   decOpB;
	corePkg::imm_t    decImm;
	logic             decIllegal;
	corePkg::ctrl_t   exCtrl;
	corePkg::word_t   exOpA;
	corePkg::word_t   exOpB;
	corePkg::imm_t    exImm;
	corePkg::regSel_t exDest;
	logic             exValid;
	logic             exErr;
	corePkg::word_t   aluResult;
	logic             fwdEn;
	logic             acceptValid;
	logic             haltSeen;
	logic             haltFlag;

	// Halt becomes visible at its writeback slot and then sticks until reset
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			haltFlag <= 1'b0;
		end else if (haltSeen) begin
			haltFlag <= 1'b1;
		end
	end

	assign halted = haltFlag | haltSeen;

	// A HALT still in execute squashes the instruction right behind it
	assign acceptValid = instrValid & ~halted & ~exCtrl.halt;

	// The execute stage result also feeds the register file on the same edge
	assign fwdEn = exValid & exCtrl.regWrite;

	instrDecode u_decode (
		.instr     (instr),
		.instrValid(acceptValid),
		.rdData1   (rdData1),
		.rdData2   (rdData2),
		.fwdEn     (fwdEn),
		.fwdReg    (exDest),
		.fwdData   (aluResult),
		.rdSel1    (rdSel1),
		.rdSel2    (rdSel2),
		.ctrl      (decCtrl),
		.destReg   (decDest),
		.opA       (decOpA),
		.opB       (decOpB),
		.imm       (decImm),
		.illegal   (decIllegal)
	);

	regFile u_regFile (
		.clk    (clk),
		.rstN   (rstN),
		.rdSel1 (rdSel1),
		.rdSel2 (rdSel2),
		.wrEn   (fwdEn),
		.wrSel  (exDest),
		.wrData (aluResult),
		.rdData1(rdData1),
		.rdData2(rdData2)
	);

	idExReg u_idEx (
		.clk      (clk),
		.rstN     (rstN),
		.ctrlIn   (decCtrl),
		.opAIn    (decOpA),
		.opBIn    (decOpB),
		.immIn    (decImm),
		.destIn   (decDest),
		.validIn  (acceptValid),
		.illegalIn(decIllegal),
		.ctrlOut  (exCtrl),
		.opAOut   (exOpA),
		.opBOut   (exOpB),
		.immOut   (exImm),
		.destOut  (exDest),
		.validOut (exValid),
		.errOut   (exErr)
	);

	aluExec u_alu (
		.clk      (clk),
		.rstN     (rstN),
		.ctrl     (exCtrl),
		.opA      (exOpA),
		.opB      (exOpB),
		.imm      (exImm),
		.dest     (exDest),
		.valid    (exValid),
		.errIn    (exErr),
		.aluResult(aluResult),
		.wbValid  (wbValid),
		.wbReg    (wbReg),
		.wbData   (wbData),
		.err      (err),
		.haltSeen (haltSeen)
	);

endmodule

// ==== tb/decodeExecCore_assert.sv ====
module coreOutputChecks (
	input logic clk,
	input logic rstN,
	input logic wbValid,
	input logic err,
	input logic halted
);

	// A writeback slot carries a result or an error, never both
	wbErrExclusive: assert property (@(posedge clk) disable iff (!rstN) !(wbValid && err))
		else $error("wbValid and err are high in the same cycle");

	haltBlocksWb: assert property (@(posedge clk) disable iff (!rstN)
		$past(halted) |-> !wbValid)
		else $error("writeback stage valid after the core had halted");

	resetClearsWb: assert property (@(posedge clk) !rstN |-> !wbValid)
		else $error("wbValid high during reset");

endmodule

bind decodeExecCore coreOutputChecks outputChecks (
	.clk    (clk),
	.rstN   (rstN),
	.wbValid(wbValid),
	.err    (err),
	.halted (halted)
);

// ==== tb/decodeExecCore_tb.sv ====
module decodeExecCore_tb;

	localparam int NumRandom   = 400;
	localparam int NumDirected = 150;
	localparam int ResetCycles = 10;
	// One instruction slot per 10 unit clock, plus both resets and some slack
	localparam int RunLimit = (NumRandom + NumDirected + 2 * ResetCycles) * 10 + 1000;

	// Opcode that the core does not implement
	localparam logic [4:0] BadOp = 5'b10000;

	typedef struct packed {
		logic             valid;
		logic             error;
		logic             halt;
		corePkg::regSel_t dest;
		corePkg::word_t   data;
	} wbExp_t;

	logic             clk;
	logic             rstN;
	corePkg::word_t   instr;
	logic             instrValid;
	logic             wbValid;
	corePkg::regSel_t wbReg;
	corePkg::word_t   wbData;
	logic             err;
	logic             halted;

	logic [15:0]      lfsr;
	corePkg::word_t   modelRegs [8];
	logic             modelHalted;
	wbExp_t           expQ [$];

	decodeExecCore uut (
		.clk       (clk),
		.rstN      (rstN),
		.instr     (instr),
		.instrValid(instrValid),
		.wbValid   (wbValid),
		.wbReg     (wbReg),
		.wbData    (wbData),
		.err       (err),
		.halted    (halted)
	);

	always #5 clk = ~clk;

	// ==========================================================
	// Stimulus generation
	// ==========================================================
	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	function automatic logic [15:0] takeBits(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[14:0], lfsr[0]};
			lfsr = lfsrNext(lfsr);
		end
		return v;
	endfunction

	function automatic corePkg::word_t encAlu(input logic [2:0] fn, input corePkg::regSel_t rs,
		input corePkg::regSel_t rt, input corePkg::regSel_t rd);
		corePkg::word_t w;
		w = '0;
		w[isaPkg::OpMsb:isaPkg::OpLsb] = isaPkg::OpAlu;
		w[isaPkg::FnHiPos] = fn[2];
		w[isaPkg::RsMsb:isaPkg::RsLsb] = rs;
		w[isaPkg::RtMsb:isaPkg::RtLsb] = rt;
		w[isaPkg::RdMsb:isaPkg::RdLsb] = rd;
		w[isaPkg::FnMsb:isaPkg::FnLsb] = fn[1:0];
		return w;
	endfunction

	// Low byte is {rs, imm5} for ADDI and XORI, or the whole immediate for LBI
	function automatic corePkg::word_t encI(input logic [4:0] op, input corePkg::regSel_t rd,
		input logic [7:0] low);
		corePkg::word_t w;
		w = '0;
		w[isaPkg::OpMsb:isaPkg::OpLsb] = op;
		w[isaPkg::IRdMsb:isaPkg::IRdLsb] = rd;
		w[isaPkg::Imm8Msb:0] = low;
		return w;
	endfunction

	function automatic corePkg::word_t randomInstr();
		logic [2:0]       kind;
		corePkg::regSel_t rs;
		corePkg::regSel_t rt;
		corePkg::regSel_t rd;
		kind = 3'(takeBits(3));
		// Registers 0 to 3 only, so neighbours often depend on each other
		rs = corePkg::regSel_t'(takeBits(2));
		rt = corePkg::regSel_t'(takeBits(2));
		rd = corePkg::regSel_t'(takeBits(2));
		case (kind)
			3'd4: return encI(isaPkg::OpAddi, rd, {rs, 5'(takeBits(5))});
			3'd5: return encI(isaPkg::OpXori, rd, {rs, 5'(takeBits(5))});
			3'd6: return encI(isaPkg::OpLbi, rd, 8'(takeBits(8)));
			3'd7: begin
				if (takeBits(1) != 16'd0) begin
					return {BadOp, 11'(takeBits(11))};
				end
				return {isaPkg::OpNop, 11'd0};
			end
			default: return encAlu(3'(takeBits(3)), rs, rt, rd);
		endcase
	endfunction

	// ==========================================================
	// Reference model
	// ==========================================================
	task automatic modelInstr(input corePkg::word_t w, input logic v, output wbExp_t e);
		logic [4:0]       op;
		logic [2:0]       fn;
		corePkg::word_t   a;
		corePkg::word_t   b;
		corePkg::word_t   res;
		corePkg::regSel_t rd;
		logic             writes;
		logic             bad;
		op = w[isaPkg::OpMsb:isaPkg::OpLsb];
		fn = {w[isaPkg::FnHiPos], w[isaPkg::FnMsb:isaPkg::FnLsb]};
		a = modelRegs[w[isaPkg::IRsMsb:isaPkg::IRsLsb]];
		rd = w[isaPkg::IRdMsb:isaPkg::IRdLsb];
		res = '0;
		writes = 1'b0;
		bad = 1'b0;
		if (!v || modelHalted) begin
			// Empty or discarded slot
			rd = '0;
		end else if (op[4:1] == isaPkg::OpAlu[4:1]) begin
			a = modelRegs[w[isaPkg::RsMsb:isaPkg::RsLsb]];
			b = modelRegs[w[isaPkg::RtMsb:isaPkg::RtLsb]];
			rd = w[isaPkg::RdMsb:isaPkg::RdLsb];
			writes = 1'b1;
			case (fn)
				isaPkg::FnAdd:  res = a + b;
				isaPkg::FnSub:  res = a - b;
				isaPkg::FnXor:  res = a ^ b;
				isaPkg::FnAndn: res = a & ~b;
				isaPkg::FnRol:  res = (a << b[3:0]) | (a >> (5'd16 - {1'b0, b[3:0]}));
				isaPkg::FnSll:  res = a << b[3:0];
				isaPkg::FnSrl:  res = a >> b[3:0];
				default: begin
					writes = 1'b0;
					bad = 1'b1;
				end
			endcase
		end else if (op == isaPkg::OpAddi) begin
			res = a + {{11{w[isaPkg::Imm5Msb]}}, w[isaPkg::Imm5Msb:0]};
			writes = 1'b1;
		end else if (op == isaPkg::OpXori) begin
			res = a ^ {11'd0, w[isaPkg::Imm5Msb:0]};
			writes = 1'b1;
		end else if (op == isaPkg::OpLbi) begin
			res = {{8{w[isaPkg::Imm8Msb]}}, w[isaPkg::Imm8Msb:0]};
			writes = 1'b1;
		end else if (op == isaPkg::OpHalt) begin
			modelHalted = 1'b1;
		end else if (op != isaPkg::OpNop) begin
			bad = 1'b1;
		end
		if (writes) begin
			modelRegs[rd] = res;
		end
		e.valid = writes;
		e.error = bad;
		e.halt  = modelHalted;
		e.dest  = rd;
		e.data  = res;
	endtask

	// ==========================================================
	// Checks
	// ==========================================================
	task automatic reportFail(input string msg);
		$display("Fail at time %0t: %s", $time, msg);
		$display("*** TEST FAILED ***");
		$fatal(1, "Stopped at the first mismatch");
	endtask

	task automatic checkWord(input corePkg::word_t got, input corePkg::word_t exp,
		input string what);
		if (got !== exp) begin
			reportFail($sformatf("%s is %h, expected %h", what, got, exp));
		end
	endtask

	task automatic checkReg(input corePkg::regSel_t got, input corePkg::regSel_t exp,
		input string what);
		if (got !== exp) begin
			reportFail($sformatf("%s is r%0d, expected r%0d", what, got, exp));
		end
	endtask

	task automatic checkFlag(input bit got, input bit exp, input string what);
		if (got != exp) begin
			reportFail($sformatf("%s is %b, expected %b", what, got, exp));
		end
	endtask

	task automatic checkSlot(input wbExp_t e);
		checkFlag(wbValid, e.valid, "wbValid");
		checkFlag(err, e.error, "err");
		checkFlag(halted, e.halt, "halted");
		if (e.valid) begin
			checkReg(wbReg, e.dest, "wbReg");
			checkWord(wbData, e.data, "wbData");
		end
	endtask

	// Drives one slot and checks the slot issued two edges earlier
	task automatic issue(input corePkg::word_t w, input logic v);
		wbExp_t e;
		@(posedge clk);
		instr <= w;
		instrValid <= v;
		modelInstr(w, v, e);
		expQ.push_back(e);
		@(negedge clk);
		while (expQ.size() > 2) begin
			e = expQ.pop_front();
			checkSlot(e);
		end
	endtask

	initial begin
		#(RunLimit);
		$display("Run timed out after %0d time units with results still missing", RunLimit);
		$display("*** TEST FAILED ***");
		$fatal(1, "Watchdog expired");
	end

	initial begin
		corePkg::word_t w;
		logic           v;
		clk = 1'b0;
		rstN = 1'b0;
		instr = '0;
		instrValid = 1'b0;
		lfsr = 16'd48;
		modelHalted = 1'b0;
		for (int i = 0; i < 8; i++) begin
			modelRegs[i] = '0;
		end
		repeat (ResetCycles) @(posedge clk);
		rstN <= 1'b1;
		@(negedge clk);
		checkFlag(wbValid, 1'b0, "wbValid after reset");
		checkFlag(err, 1'b0, "err after reset");
		checkFlag(halted, 1'b0, "halted after reset");

		// Every register reads back zero through an add of immediate zero
		for (int r = 0; r < 8; r++) begin
			issue(encI(isaPkg::OpAddi, 3'(r), {3'(r), 5'd0}), 1'b1);
		end

		for (int n = 0; n < NumRandom; n++) begin
			w = randomInstr();
			v = takeBits(2) != 16'd0;
			issue(w, v);
		end

		// Dependent chain with no gaps, every step forwarded
		issue(encI(isaPkg::OpLbi, 3'd1, 8'd5), 1'b1);
		issue(encI(isaPkg::OpAddi, 3'd1, {3'd1, 5'h1d}), 1'b1);
		issue(encAlu(isaPkg::FnAdd, 3'd1, 3'd1, 3'd2), 1'b1);
		issue(encAlu(isaPkg::FnSub, 3'd2, 3'd1, 3'd2), 1'b1);
		issue(encI(isaPkg::OpXori, 3'd2, {3'd2, 5'h1f}), 1'b1);

		issue(encI(isaPkg::OpLbi, 3'd6, 8'ha5), 1'b1);
		for (int s = 0; s < 16; s++) begin
			issue(encI(isaPkg::OpLbi, 3'd4, 8'(s)), 1'b1);
			issue(encAlu(isaPkg::FnRol, 3'd6, 3'd4, 3'd5), 1'b1);
			issue(encAlu(isaPkg::FnSll, 3'd6, 3'd4, 3'd5), 1'b1);
			issue(encAlu(isaPkg::FnSrl, 3'd6, 3'd4, 3'd7), 1'b1);
		end

		issue(encAlu(3'd7, 3'd1, 3'd2, 3'd3), 1'b1);
		issue({BadOp, 11'h2a5}, 1'b1);
		issue(encAlu(isaPkg::FnAdd, 3'd3, 3'd3, 3'd3), 1'b1);

		// Nothing after the HALT may reach writeback
		issue({isaPkg::OpHalt, 11'd0}, 1'b1);
		for (int n = 0; n < 20; n++) begin
			issue(randomInstr(), 1'b1);
		end
		repeat (2) issue('0, 1'b0);

		@(posedge clk);
		rstN <= 1'b0;
		instrValid <= 1'b0;
		repeat (ResetCycles) @(posedge clk);
		rstN <= 1'b1;
		@(negedge clk);
		checkFlag(halted, 1'b0, "halted after final reset");
		checkFlag(wbValid, 1'b0, "wbValid after final reset");
		checkFlag(err, 1'b0, "err after final reset");
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

// ==== decodeExecCore.f ====
rtl/isaPkg.sv
rtl/corePkg.sv
rtl/instrDecode.sv
rtl/regFile.sv
rtl/idExReg.sv
rtl/aluExec.sv
rtl/decodeExecCore.sv
tb/decodeExecCore_assert.sv
tb/decodeExecCore_tb.sv

// ==== run.sh ====
#!/bin/bash
# Builds and runs the decodeExecCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	--top-module decodeExecCore_tb \
	-f decodeExecCore.f \
	--Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/simv 2>&1)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qF "*** TEST PASSED ***"; then
	exit 0
fi
echo "Pass message not found in simulation output"
exit 1
